// File: hw/lce_cmd_fsm.sv
// ********************
// sync is only served before all NUM_CCE syncs are answered
// coherent commands stall until then
// uc_data is served in both phases
// ********************
`timescale 1ns/100ps

module lce_cmd_fsm (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  init_done_i,
  input  logic [lce_cmd_pkg::ID_WIDTH-1:0]      lce_id_i,
  input  logic [lce_cmd_pkg::PADDR_WIDTH-1:0]   miss_addr_i,

  input  logic                                  cmd_v_i,
  input  lce_cmd_pkg::lce_cmd_msg_e             cmd_msg_i,
  input  logic [lce_cmd_pkg::PADDR_WIDTH-1:0]   cmd_addr_i,
  input  logic [lce_cmd_pkg::WAY_WIDTH-1:0]     cmd_way_i,
  input  lce_cmd_pkg::coh_state_e               cmd_state_i,
  input  logic [lce_cmd_pkg::ID_WIDTH-1:0]      cmd_src_i,
  input  logic [lce_cmd_pkg::BLOCK_WIDTH-1:0]   cmd_data_i,
  output logic                                  cmd_yumi_o,

  output logic                                  resp_v_o,
  output lce_cmd_pkg::lce_resp_msg_e            resp_msg_o,
  output logic [lce_cmd_pkg::ID_WIDTH-1:0]      resp_dst_o,
  output logic [lce_cmd_pkg::PADDR_WIDTH-1:0]   resp_addr_o,
  input  logic                                  resp_yumi_i,

  output logic                                  lce_ready_o,
  output logic                                  set_tag_received_o,
  output logic                                  set_tag_wakeup_received_o,
  output logic                                  cce_data_received_o,
  output logic                                  uncached_data_received_o,
  output logic                                  cache_req_complete_o,

  lce_tag_if.producer                           tag,
  lce_data_if.producer                          data
);
  import lce_cmd_pkg::*;

  typedef enum logic [1:0] {
    e_wait_init,
    e_uncached_only,
    e_ready
  } fsm_state_e;

  fsm_state_e                state_r, state_n;
  logic [SYNC_CNT_WIDTH-1:0] sync_cnt_r, sync_cnt_n;
  logic                      inv_pend_r, inv_pend_n;

  logic [INDEX_WIDTH-1:0]    cmd_index;
  logic [TAG_WIDTH-1:0]      cmd_tag;
  logic [INDEX_WIDTH-1:0]    miss_index;
  logic [ID_WIDTH-1:0]       resp_src;
  logic                      coh_ok;

  assign cmd_index  = cmd_addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
  assign cmd_tag    = cmd_addr_i[OFFSET_WIDTH + INDEX_WIDTH +: TAG_WIDTH];
  assign miss_index = miss_addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
  assign resp_src   = lce_id_i;
  assign coh_ok     = (state_r == e_ready);

  always_comb begin
    state_n    = state_r;
    sync_cnt_n = sync_cnt_r;
    inv_pend_n = inv_pend_r;

    cmd_yumi_o  = 1'b0;
    resp_v_o    = 1'b0;
    resp_msg_o  = e_resp_sync_ack;
    resp_dst_o  = cmd_src_i;
    resp_addr_o = cmd_addr_i;

    tag.v     = 1'b0;
    tag.index = cmd_index;
    tag.way   = cmd_way_i;
    tag.state = cmd_state_i;
    tag.tag   = cmd_tag;
    tag.op    = e_tag_set_tag;

    data.v     = 1'b0;
    data.index = miss_index;
    data.way   = cmd_way_i;
    data.op    = e_data_write;
    data.data  = cmd_data_i;

    lce_ready_o               = (state_r != e_wait_init);
    set_tag_received_o        = 1'b0;
    set_tag_wakeup_received_o = 1'b0;
    cce_data_received_o       = 1'b0;
    uncached_data_received_o  = 1'b0;
    cache_req_complete_o      = 1'b0;

    if (state_r == e_wait_init) begin
      if (init_done_i) begin
        state_n = e_uncached_only;
      end
    end else if (cmd_v_i) begin
      case (cmd_msg_i)
        e_cmd_sync: begin
          if (state_r == e_uncached_only) begin
            resp_v_o   = 1'b1;
            cmd_yumi_o = resp_yumi_i;
            if (resp_yumi_i) begin
              if (sync_cnt_r == SYNC_CNT_WIDTH'(NUM_CCE - 1)) begin
                state_n    = e_ready;
                sync_cnt_n = '0;
              end else begin
                sync_cnt_n = sync_cnt_r + 1'b1;
              end
            end
          end
        end
        e_cmd_set_tag, e_cmd_set_tag_wakeup: begin
          if (coh_ok) begin
            tag.v      = tag.ready;
            cmd_yumi_o = tag.ready;
            if (cmd_msg_i == e_cmd_set_tag) begin
              set_tag_received_o = tag.ready;
            end else begin
              set_tag_wakeup_received_o = tag.ready;
              cache_req_complete_o      = tag.ready;
            end
          end
        end
        e_cmd_invalidate: begin
          if (coh_ok) begin
            // tag write first, then hold the ack until it is taken
            tag.v      = ~inv_pend_r & tag.ready;
            tag.state  = e_coh_invalid;
            tag.tag    = '0;
            tag.op     = e_tag_invalidate;
            resp_v_o   = inv_pend_r | tag.v;
            resp_msg_o = e_resp_inv_ack;
            cmd_yumi_o = resp_v_o & resp_yumi_i;
            inv_pend_n = resp_v_o & ~resp_yumi_i;
          end
        end
        e_cmd_writeback: begin
          if (coh_ok) begin
            resp_v_o   = 1'b1;
            resp_msg_o = e_resp_null_wb;
            cmd_yumi_o = resp_yumi_i;
          end
        end
        e_cmd_data: begin
          if (coh_ok) begin
            tag.index            = miss_index;
            tag.v                = tag.ready & data.ready;
            data.v               = tag.ready & data.ready;
            cmd_yumi_o           = data.v;
            cce_data_received_o  = data.v;
            set_tag_received_o   = data.v;
            cache_req_complete_o = data.v;
          end
        end
        e_cmd_uc_data: begin
          data.v                   = data.ready;
          data.op                  = e_data_uncached;
          cmd_yumi_o               = data.ready;
          uncached_data_received_o = data.ready;
          cache_req_complete_o     = data.ready;
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= e_wait_init;
      sync_cnt_r <= '0;
      inv_pend_r <= 1'b0;
    end else begin
      state_r    <= state_n;
      sync_cnt_r <= sync_cnt_n;
      inv_pend_r <= inv_pend_n;
    end
  end

  // response stays offered and unchanged until the receiver takes it
  a_resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o && !resp_yumi_i |=> resp_v_o &&
      $stable({resp_msg_o, resp_dst_o, resp_addr_o, resp_src}));

  a_yumi_needs_v: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_yumi_o |-> cmd_v_i);

endmodule

// File: hw/lce_cmd_pkg.sv
// ********************
// sizes assume a 16-set, 4-way icache with 64-bit blocks and 22-bit paddr
// NUM_SETS and NUM_WAYS must be powers of two
// ********************
package lce_cmd_pkg;

  // cache geometry
  localparam int NUM_SETS     = 16;
  localparam int NUM_WAYS     = 4;
  localparam int NUM_CCE      = 2;
  localparam int BLOCK_WIDTH  = 64;
  localparam int PADDR_WIDTH  = 22;
  localparam int OFFSET_WIDTH = 3;
  localparam int INDEX_WIDTH  = $clog2(NUM_SETS);
  localparam int TAG_WIDTH    = PADDR_WIDTH - OFFSET_WIDTH - INDEX_WIDTH;
  localparam int WAY_WIDTH    = $clog2(NUM_WAYS);
  localparam int ID_WIDTH     = 2;

  // wide enough to count all sync commands
  localparam int SYNC_CNT_WIDTH = $clog2(NUM_CCE + 1);

  typedef enum logic [2:0] {
    e_cmd_sync,
    e_cmd_set_tag,
    e_cmd_set_tag_wakeup,
    e_cmd_invalidate,
    e_cmd_writeback,
    e_cmd_data,
    e_cmd_uc_data
  } lce_cmd_msg_e;

  typedef enum logic [1:0] {
    e_resp_sync_ack,
    e_resp_inv_ack,
    e_resp_null_wb
  } lce_resp_msg_e;

  typedef enum logic [1:0] {
    e_coh_invalid,
    e_coh_shared,
    e_coh_exclusive
  } coh_state_e;

  typedef enum logic [1:0] {
    e_tag_set_clear,
    e_tag_set_tag,
    e_tag_invalidate
  } tag_op_e;

  typedef enum logic {
    e_data_write,
    e_data_uncached
  } data_op_e;

endpackage

// File: hw/lce_cmd_top.sv
// ********************
// tag and data arrays attach through plain valid/ready ports
// commands and responses use valid/yumi
// ********************
`timescale 1ns/100ps

module lce_cmd_top (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [lce_cmd_pkg::ID_WIDTH-1:0]      lce_id_i,
  input  logic [lce_cmd_pkg::PADDR_WIDTH-1:0]   miss_addr_i,

  input  logic                                  cmd_v_i,
  input  lce_cmd_pkg::lce_cmd_msg_e             cmd_msg_i,
  input  logic [lce_cmd_pkg::PADDR_WIDTH-1:0]   cmd_addr_i,
  input  logic [lce_cmd_pkg::WAY_WIDTH-1:0]     cmd_way_i,
  input  lce_cmd_pkg::coh_state_e               cmd_state_i,
  input  logic [lce_cmd_pkg::ID_WIDTH-1:0]      cmd_src_i,
  input  logic [lce_cmd_pkg::BLOCK_WIDTH-1:0]   cmd_data_i,
  output logic                                  cmd_yumi_o,

  output logic                                  resp_v_o,
  output lce_cmd_pkg::lce_resp_msg_e            resp_msg_o,
  output logic [lce_cmd_pkg::ID_WIDTH-1:0]      resp_dst_o,
  output logic [lce_cmd_pkg::PADDR_WIDTH-1:0]   resp_addr_o,
  input  logic                                  resp_yumi_i,

  output logic                                  lce_ready_o,
  output logic                                  set_tag_received_o,
  output logic                                  set_tag_wakeup_received_o,
  output logic                                  cce_data_received_o,
  output logic                                  uncached_data_received_o,
  output logic                                  cache_req_complete_o,

  output logic                                  tag_v_o,
  input  logic                                  tag_ready_i,
  output logic [lce_cmd_pkg::INDEX_WIDTH-1:0]   tag_index_o,
  output logic [lce_cmd_pkg::WAY_WIDTH-1:0]     tag_way_o,
  output lce_cmd_pkg::coh_state_e               tag_state_o,
  output logic [lce_cmd_pkg::TAG_WIDTH-1:0]     tag_tag_o,
  output lce_cmd_pkg::tag_op_e                  tag_op_o,

  output logic                                  data_v_o,
  input  logic                                  data_ready_i,
  output logic [lce_cmd_pkg::INDEX_WIDTH-1:0]   data_index_o,
  output logic [lce_cmd_pkg::WAY_WIDTH-1:0]     data_way_o,
  output lce_cmd_pkg::data_op_e                 data_op_o,
  output logic [lce_cmd_pkg::BLOCK_WIDTH-1:0]   data_o
);

  logic init_done;

  lce_tag_if  cmd_tag_if ();
  lce_tag_if  mem_tag_if ();
  lce_data_if data_if ();

  assign tag_v_o          = mem_tag_if.v;
  assign mem_tag_if.ready = tag_ready_i;
  assign tag_index_o      = mem_tag_if.index;
  assign tag_way_o        = mem_tag_if.way;
  assign tag_state_o      = mem_tag_if.state;
  assign tag_tag_o        = mem_tag_if.tag;
  assign tag_op_o         = mem_tag_if.op;

  assign data_v_o         = data_if.v;
  assign data_if.ready    = data_ready_i;
  assign data_index_o     = data_if.index;
  assign data_way_o       = data_if.way;
  assign data_op_o        = data_if.op;
  assign data_o           = data_if.data;

  lce_init_sweep u_sweep (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .cmd_tag (cmd_tag_if.consumer),
    .mem_tag (mem_tag_if.producer),
    .done_o  (init_done)
  );

  lce_cmd_fsm u_fsm (
    .clk_i                     (clk_i),
    .reset_i                   (reset_i),
    .init_done_i               (init_done),
    .lce_id_i                  (lce_id_i),
    .miss_addr_i               (miss_addr_i),
    .cmd_v_i                   (cmd_v_i),
    .cmd_msg_i                 (cmd_msg_i),
    .cmd_addr_i                (cmd_addr_i),
    .cmd_way_i                 (cmd_way_i),
    .cmd_state_i               (cmd_state_i),
    .cmd_src_i                 (cmd_src_i),
    .cmd_data_i                (cmd_data_i),
    .cmd_yumi_o                (cmd_yumi_o),
    .resp_v_o                  (resp_v_o),
    .resp_msg_o                (resp_msg_o),
    .resp_dst_o                (resp_dst_o),
    .resp_addr_o               (resp_addr_o),
    .resp_yumi_i               (resp_yumi_i),
    .lce_ready_o               (lce_ready_o),
    .set_tag_received_o        (set_tag_received_o),
    .set_tag_wakeup_received_o (set_tag_wakeup_received_o),
    .cce_data_received_o       (cce_data_received_o),
    .uncached_data_received_o  (uncached_data_received_o),
    .cache_req_complete_o      (cache_req_complete_o),
    .tag                       (cmd_tag_if.producer),
    .data                      (data_if.producer)
  );

endmodule

// File: hw/lce_init_sweep.sv
// ********************
// clears one tag set per accepted packet after reset
// sweep packets carry way zero
// command-side tag packets are blocked until the sweep has finished
// ********************
`timescale 1ns/100ps

module lce_init_sweep (
  input  logic           clk_i,
  input  logic           reset_i,
  lce_tag_if.consumer    cmd_tag,
  lce_tag_if.producer    mem_tag,
  output logic           done_o
);
  import lce_cmd_pkg::*;

  logic [INDEX_WIDTH-1:0] idx_r;
  logic                   done_r;
  logic                   sweep_fire;
  logic                   sweep_last;

  assign sweep_fire = ~done_r & mem_tag.ready;
  assign sweep_last = sweep_fire & (idx_r == INDEX_WIDTH'(NUM_SETS - 1));

  // high already in the last sweep cycle so the fsm leaves init right after it
  assign done_o = done_r | sweep_last;

  assign mem_tag.v     = done_r ? cmd_tag.v     : mem_tag.ready;
  assign mem_tag.index = done_r ? cmd_tag.index : idx_r;
  assign mem_tag.way   = done_r ? cmd_tag.way   : '0;
  assign mem_tag.state = done_r ? cmd_tag.state : e_coh_invalid;
  assign mem_tag.tag   = done_r ? cmd_tag.tag   : '0;
  assign mem_tag.op    = done_r ? cmd_tag.op    : e_tag_set_clear;
  assign cmd_tag.ready = done_r & mem_tag.ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      idx_r  <= '0;
      done_r <= 1'b0;
    end else if (sweep_fire) begin
      idx_r  <= idx_r + 1'b1;
      done_r <= sweep_last;
    end
  end

  // the fsm relies on init staying complete
  a_done_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
    done_o |=> done_o);

endmodule

// File: hw/lce_mem_if.sv
// ********************
// a packet is written when v and ready are both high
// producers raise v only while ready is high
// ********************
`timescale 1ns/100ps

interface lce_tag_if;
  import lce_cmd_pkg::*;

  logic                   v;
  logic                   ready;
  logic [INDEX_WIDTH-1:0] index;
  logic [WAY_WIDTH-1:0]   way;
  coh_state_e             state;
  logic [TAG_WIDTH-1:0]   tag;
  tag_op_e                op;

  modport producer (output v, index, way, state, tag, op, input ready);
  modport consumer (input v, index, way, state, tag, op, output ready);
endinterface

interface lce_data_if;
  import lce_cmd_pkg::*;

  logic                   v;
  logic                   ready;
  logic [INDEX_WIDTH-1:0] index;
  logic [WAY_WIDTH-1:0]   way;
  data_op_e               op;
  logic [BLOCK_WIDTH-1:0] data;

  modport producer (output v, index, way, op, data, input ready);
  modport consumer (input v, index, way, op, data, output ready);
endinterface

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_lce_cmd -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then
  exit 1
fi
exit 0

// File: src.f
+incdir+verif
hw/lce_cmd_pkg.sv
hw/lce_mem_if.sv
hw/lce_init_sweep.sv
hw/lce_cmd_fsm.sv
hw/lce_cmd_top.sv
verif/tb_lce_cmd.sv

// File: verif/tb_lce_model.svh
// ********************
// expected packets, responses and status pulses per command opcode
// needs lce_cmd_pkg imported by the including module
// ********************
`ifndef TB_LCE_MODEL_SVH
`define TB_LCE_MODEL_SVH

function automatic logic [INDEX_WIDTH-1:0] addr_index(input logic [PADDR_WIDTH-1:0] a);
  return a[OFFSET_WIDTH +: INDEX_WIDTH];
endfunction

function automatic logic [TAG_WIDTH-1:0] addr_tag(input logic [PADDR_WIDTH-1:0] a);
  return a[PADDR_WIDTH-1 -: TAG_WIDTH];
endfunction

function automatic int model_tag_writes(input lce_cmd_msg_e m);
  return (m == e_cmd_set_tag || m == e_cmd_set_tag_wakeup ||
          m == e_cmd_invalidate || m == e_cmd_data) ? 1 : 0;
endfunction

function automatic int model_data_writes(input lce_cmd_msg_e m);
  return (m == e_cmd_data || m == e_cmd_uc_data) ? 1 : 0;
endfunction

function automatic int model_resps(input lce_cmd_msg_e m);
  return (m == e_cmd_sync || m == e_cmd_invalidate || m == e_cmd_writeback) ? 1 : 0;
endfunction

// fills index the set of the outstanding miss
function automatic logic [INDEX_WIDTH-1:0] model_tag_index(input lce_cmd_msg_e m,
    input logic [PADDR_WIDTH-1:0] addr, input logic [PADDR_WIDTH-1:0] miss);
  return (m == e_cmd_data) ? addr_index(miss) : addr_index(addr);
endfunction

function automatic lce_resp_msg_e model_resp_msg(input lce_cmd_msg_e m);
  if (m == e_cmd_invalidate) return e_resp_inv_ack;
  if (m == e_cmd_writeback) return e_resp_null_wb;
  return e_resp_sync_ack;
endfunction

// {set_tag, set_tag_wakeup, cce_data, uncached_data, req_complete}
function automatic logic [4:0] model_pulses(input lce_cmd_msg_e m);
  case (m)
    e_cmd_set_tag:        return 5'b10000;
    e_cmd_set_tag_wakeup: return 5'b01001;
    e_cmd_data:           return 5'b10101;
    e_cmd_uc_data:        return 5'b00011;
    default:              return 5'b00000;
  endcase
endfunction

// the handshake that ends each command
function automatic bit model_done(input lce_cmd_msg_e m, input bit tag_f,
    input bit data_f, input bit resp_f);
  case (m)
    e_cmd_set_tag, e_cmd_set_tag_wakeup: return tag_f;
    e_cmd_data:    return tag_f & data_f;
    e_cmd_uc_data: return data_f;
    default:       return resp_f;
  endcase
endfunction

`endif

// File: verif/tb_lce_cmd.sv
// ********************
// random back-pressure on tag, data and response ports
// stimulus repeats from a fixed seed
// ********************
`timescale 1ns/100ps

module tb_lce_cmd;
  import lce_cmd_pkg::*;
  `include "tb_lce_model.svh"

  localparam int CLK_PERIOD = 8;
  localparam int NUM_CMDS   = 16;

  logic                   clk_i, reset_i;
  logic [ID_WIDTH-1:0]    lce_id_i;
  logic [PADDR_WIDTH-1:0] miss_addr_i, cmd_addr_i, resp_addr_o;
  logic                   cmd_v_i, cmd_yumi_o, resp_v_o, resp_yumi_i;
  lce_cmd_msg_e           cmd_msg_i;
  logic [WAY_WIDTH-1:0]   cmd_way_i, tag_way_o, data_way_o;
  coh_state_e             cmd_state_i, tag_state_o;
  logic [ID_WIDTH-1:0]    cmd_src_i, resp_dst_o;
  logic [BLOCK_WIDTH-1:0] cmd_data_i, data_o;
  lce_resp_msg_e          resp_msg_o;
  logic                   lce_ready_o, set_tag_received_o, set_tag_wakeup_received_o;
  logic                   cce_data_received_o, uncached_data_received_o;
  logic                   cache_req_complete_o;
  logic                   tag_v_o, tag_ready_i, data_v_o, data_ready_i;
  logic [INDEX_WIDTH-1:0] tag_index_o, data_index_o;
  logic [TAG_WIDTH-1:0]   tag_tag_o;
  tag_op_e                tag_op_o;
  data_op_e               data_op_o;

  integer seed = 32'h915;
  int     errors = 0;
  int     checks = 0;

  lce_cmd_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #((10 + 200 * (NUM_CMDS + 1)) * CLK_PERIOD);
    $display("watchdog expired, a command was never accepted");
    $display("TEST FAILED");
    $finish;
  end

  function automatic bit chance70();
    return ($unsigned($random(seed)) % 100) < 70;
  endfunction

  task automatic error(input string msg);
    errors++;
    $display("ERROR @%0t: %s", $time, msg);
  endtask

  task automatic check_tag(input tag_op_e op, input coh_state_e st,
      input logic [INDEX_WIDTH-1:0] idx, input logic [WAY_WIDTH-1:0] way,
      input logic [TAG_WIDTH-1:0] tg);
    checks++;
    if (tag_op_o !== op || tag_state_o !== st || tag_index_o !== idx ||
        tag_way_o !== way || tag_tag_o !== tg)
      error($sformatf("tag got %s/%s i%0h w%0h t%0h, exp %s/%s i%0h w%0h t%0h",
        tag_op_o.name(), tag_state_o.name(), tag_index_o, tag_way_o, tag_tag_o,
        op.name(), st.name(), idx, way, tg));
  endtask

  task automatic check_data(input data_op_e op, input logic [INDEX_WIDTH-1:0] idx,
      input logic [WAY_WIDTH-1:0] way, input logic [BLOCK_WIDTH-1:0] blk);
    checks++;
    if (data_op_o !== op || data_index_o !== idx || data_way_o !== way || data_o !== blk)
      error($sformatf("data got %s i%0h w%0h d%0h, exp %s i%0h w%0h d%0h",
        data_op_o.name(), data_index_o, data_way_o, data_o,
        op.name(), idx, way, blk));
  endtask

  task automatic check_resp(input lce_resp_msg_e msg, input logic [ID_WIDTH-1:0] dst,
      input logic [PADDR_WIDTH-1:0] addr);
    checks++;
    if (resp_msg_o !== msg || resp_dst_o !== dst || resp_addr_o !== addr)
      error($sformatf("resp got %s d%0h a%0h, exp %s d%0h a%0h",
        resp_msg_o.name(), resp_dst_o, resp_addr_o, msg.name(), dst, addr));
  endtask

  // yumi followed by the five status pulses
  task automatic check_status(input logic [5:0] exp);
    logic [5:0] got;
    got = {cmd_yumi_o, set_tag_received_o, set_tag_wakeup_received_o,
           cce_data_received_o, uncached_data_received_o, cache_req_complete_o};
    checks++;
    if (got !== exp)
      error($sformatf("yumi/status got %b, exp %b", got, exp));
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp)
      error($sformatf("%s count %0d, exp %0d", what, got, exp));
  endtask

  task automatic drive_readies();
    tag_ready_i  <= chance70();
    data_ready_i <= chance70();
    resp_yumi_i  <= chance70();
  endtask

  task automatic run_cmd(input lce_cmd_msg_e msg);
    logic [PADDR_WIDTH-1:0] addr, miss;
    logic [WAY_WIDTH-1:0]   way;
    coh_state_e             st, exp_st;
    logic [ID_WIDTH-1:0]    src;
    logic [BLOCK_WIDTH-1:0] blk;
    logic [TAG_WIDTH-1:0]   exp_tg;
    int                     n_tag, n_data, n_resp;
    bit                     tag_f, data_f, resp_f, fin, done;
    addr   = PADDR_WIDTH'($random(seed));
    miss   = PADDR_WIDTH'($random(seed));
    way    = WAY_WIDTH'($random(seed));
    st     = coh_state_e'($unsigned($random(seed)) % 3);
    src    = ID_WIDTH'($random(seed));
    blk    = {$random(seed), $random(seed)};
    // an invalidated line keeps no tag
    exp_st = (msg == e_cmd_invalidate) ? e_coh_invalid : st;
    exp_tg = (msg == e_cmd_invalidate) ? '0 : addr_tag(addr);
    n_tag  = 0;
    n_data = 0;
    n_resp = 0;
    done   = 1'b0;
    @(posedge clk_i);
    cmd_v_i     <= 1'b1;
    cmd_msg_i   <= msg;
    cmd_addr_i  <= addr;
    miss_addr_i <= miss;
    cmd_way_i   <= way;
    cmd_state_i <= st;
    cmd_src_i   <= src;
    cmd_data_i  <= blk;
    drive_readies();
    while (!done) begin
      @(negedge clk_i);
      tag_f  = tag_v_o && tag_ready_i;
      data_f = data_v_o && data_ready_i;
      resp_f = resp_v_o && resp_yumi_i;
      if (tag_f) begin
        n_tag++;
        check_tag(msg == e_cmd_invalidate ? e_tag_invalidate : e_tag_set_tag, exp_st,
          model_tag_index(msg, addr, miss), way, exp_tg);
        if (msg == e_cmd_invalidate && !resp_v_o)
          error("inv_ack not offered in the cycle of its tag write");
      end
      if (data_f) begin
        n_data++;
        check_data(msg == e_cmd_uc_data ? e_data_uncached : e_data_write,
          addr_index(miss), way, blk);
      end
      if (resp_f) begin
        n_resp++;
        check_resp(model_resp_msg(msg), src, addr);
        if (n_tag != model_tag_writes(msg))
          error("response taken before its tag write");
      end
      fin = model_done(msg, tag_f, data_f, resp_f);
      check_status(fin ? {1'b1, model_pulses(msg)} : 6'b0);
      if (!lce_ready_o)
        error("lce_ready_o dropped after init");
      done = cmd_yumi_o;
      @(posedge clk_i);
      drive_readies();
      if (done)
        cmd_v_i <= 1'b0;
    end
    check_count({msg.name(), " tag writes"}, n_tag, model_tag_writes(msg));
    check_count({msg.name(), " data writes"}, n_data, model_data_writes(msg));
    check_count({msg.name(), " responses"}, n_resp, model_resps(msg));
  endtask

  task automatic end_test(input string name);
    $display("%s finished, %0d errors so far", name, errors);
  endtask

  initial begin
    int sweep_cnt;
    int late_cycles;
    reset_i      = 1'b1;
    lce_id_i     = 2'd1;
    miss_addr_i  = '0;
    cmd_v_i      = 1'b0;
    cmd_msg_i    = e_cmd_sync;
    cmd_addr_i   = '0;
    cmd_way_i    = '0;
    cmd_state_i  = e_coh_invalid;
    cmd_src_i    = '0;
    cmd_data_i   = '0;
    resp_yumi_i  = 1'b0;
    tag_ready_i  = 1'b0;
    data_ready_i = 1'b0;
    sweep_cnt    = 0;
    late_cycles  = 0;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    drive_readies();
    @(negedge clk_i);
    while (!lce_ready_o) begin
      // ready is due in the cycle right after the last sweep write
      if (sweep_cnt == NUM_SETS)
        late_cycles++;
      if (tag_v_o && tag_ready_i) begin
        check_tag(e_tag_set_clear, e_coh_invalid, INDEX_WIDTH'(sweep_cnt), '0, '0);
        sweep_cnt++;
      end
      @(posedge clk_i);
      drive_readies();
      @(negedge clk_i);
    end
    check_count("sweep tag writes", sweep_cnt, NUM_SETS);
    check_count("late lce_ready_o cycles", late_cycles, 0);
    end_test("reset sweep");

    run_cmd(e_cmd_uc_data);
    repeat (NUM_CCE) run_cmd(e_cmd_sync);
    end_test("sync phase");

    repeat (2) begin
      run_cmd(e_cmd_set_tag);
      run_cmd(e_cmd_set_tag_wakeup);
    end
    end_test("set tag and wakeup");

    repeat (4) run_cmd(e_cmd_invalidate);
    end_test("invalidate");

    repeat (3) run_cmd(e_cmd_data);
    repeat (2) run_cmd(e_cmd_writeback);
    end_test("data fill and writeback");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
